// File: list.f
cpu_pkg.sv
wb_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
bus_arbiter.sv
cpu_top.sv
tb_memory.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - cpu_pkg.sv
  - wb_pkg.sv
  - fetch_unit.sv
  - decode_unit.sv
  - execute_unit.sv
  - bus_arbiter.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_memory.sv
      - tb_cpu.sv

// File: tb_cpu.sv
// --------------------
// testbench for cpu_top that runs small hand assembled programs
// and compares the retire trace with values from the instruction rules
// --------------------
`timescale 1ns/100ps

module tb_cpu
    import cpu_pkg::*;
    import wb_pkg::*;
();

    localparam int          retire_timeout = 400;            // cycles per awaited event
    localparam word_t       nop_instr      = 32'h14000000;   // never taken bne as a nop
    localparam int unsigned rand_seed      = 32'h86ac1520;

    logic    clk;
    logic    resetn;
    logic    rand_delay;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    retire_t retire;

    word_t       prog [64];
    int          prog_len;
    word_t       exp_pc [32];
    word_t       exp_rd [32];
    word_t       exp_data [32];
    int          n_exp;

    cpu_top #(
        .reset_vector (32'h00000000)
    ) UUT (
        .clk     (clk),
        .resetn  (resetn),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .retire  (retire)
    );

    tb_memory #(
        .seed (rand_seed)
    ) u_mem (
        .clk          (clk),
        .resetn       (resetn),
        .random_delay (rand_delay),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // checking and encoding
    // --------------------
    task automatic check_value(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic word_t enc_r(funct_t fn, int rd, int rs, int rt, int shamt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t enc_j(word_t target);
        return {op_j, target[27:2]};
    endfunction

    // --------------------
    // program building
    // --------------------
    task automatic begin_program();
        prog_len = 0;
        n_exp    = 0;
    endtask

    task automatic emit(word_t instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_write(word_t pc, int rd, word_t data);
        exp_pc[n_exp]   = pc;
        exp_rd[n_exp]   = word_t'(rd);
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // park in a jump to itself with a nop in the delay slot
    task automatic end_program();
        emit(enc_j(word_t'(prog_len * 4)));
        emit(nop_instr);
    endtask

    task automatic apply_reset();
        int i;
        @(negedge clk);
        resetn = 1'b0;
        u_mem.fill();
        for (i = 0; i < prog_len; i++) begin
            u_mem.write_word(word_t'(i * 4), prog[i]);
        end
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value(word_t'(retire.valid), 32'd0, "retire valid during reset");
            check_value(word_t'(bus_req.cyc), 32'd0, "bus cyc during reset");
        end
        resetn = 1'b1;
    endtask

    task automatic run_and_compare(string name);
        int k;
        int cycles;
        apply_reset();
        for (k = 0; k < n_exp; k++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > retire_timeout) begin
                    report_timeout($sformatf("retire entry %0d of %s", k, name));
                end
            end while (!retire.valid);
            check_value(retire.pc, exp_pc[k], $sformatf("%s retire %0d pc", name, k));
            check_value(word_t'(retire.rd), exp_rd[k], $sformatf("%s retire %0d rd", name, k));
            check_value(retire.data, exp_data[k], $sformatf("%s retire %0d data", name, k));
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic build_arith();
        word_t v [13];
        int    r;
        v[1]  = 32'hfffffffb;
        v[2]  = v[1] + v[1];
        v[3]  = v[1] - v[2];
        v[4]  = v[3] & v[2];
        v[5]  = v[4] | v[1];
        v[6]  = v[5] ^ v[3];
        v[7]  = ($signed(v[6]) < $signed(v[3])) ? 32'd1 : 32'd0;
        v[8]  = v[7] << 9;
        v[9]  = 32'h84210000;
        v[10] = v[9] | 32'h00000f0f;
        v[11] = v[10] & 32'h0000ff00;
        v[12] = v[11] + v[8];
        begin_program();
        emit(enc_i(op_addiu, 0, 1, -5));
        emit(enc_r(fn_addu, 2, 1, 1, 0));
        emit(enc_r(fn_subu, 3, 1, 2, 0));
        emit(enc_r(fn_and, 4, 3, 2, 0));
        emit(enc_r(fn_or, 5, 4, 1, 0));
        emit(enc_r(fn_xor, 6, 5, 3, 0));
        emit(enc_r(fn_slt, 7, 6, 3, 0));
        emit(enc_r(fn_sll, 8, 0, 7, 9));
        emit(enc_i(op_lui, 0, 9, 16'h8421));
        emit(enc_i(op_ori, 9, 10, 16'h0f0f));
        emit(enc_i(op_andi, 10, 11, 16'hff00));
        emit(enc_r(fn_addu, 12, 11, 8, 0));
        for (r = 1; r <= 12; r++) begin
            expect_write(word_t'((r - 1) * 4), r, v[r]);     // one write per word
        end
        end_program();
    endtask

    task automatic test_reset();
        int cycles;
        build_arith();
        apply_reset();
        cycles = 0;
        while (!bus_req.stb) begin
            check_value(word_t'(retire.valid), 32'd0, "retire valid before first fetch");
            @(negedge clk);
            cycles++;
            if (cycles > retire_timeout) begin
                report_timeout("the first bus request");
            end
        end
        check_value(bus_req.adr, 32'h00000000, "first fetch address");
        check_value(word_t'(bus_req.we), 32'd0, "first request write enable");
        check_value(word_t'(bus_req.sel), 32'h0000000f, "first request byte select");
    endtask

    task automatic test_arith(logic random_acks);
        rand_delay = random_acks;
        build_arith();
        run_and_compare(random_acks ? "arith random" : "arith");
        rand_delay = 1'b0;
    endtask

    task automatic test_memory();
        word_t hi;
        word_t val;
        hi  = 32'h12340000;
        val = hi | 32'h00005678;
        begin_program();
        emit(enc_i(op_lui, 0, 1, 16'h1234));
        emit(enc_i(op_ori, 1, 1, 16'h5678));
        emit(enc_i(op_addiu, 0, 2, 16'h0100));
        emit(enc_i(op_sw, 2, 1, 0));
        emit(enc_i(op_lw, 2, 3, 0));
        emit(enc_r(fn_addu, 4, 3, 1, 0));                   // uses the load at once
        expect_write(32'h00, 1, hi);
        expect_write(32'h04, 1, val);
        expect_write(32'h08, 2, 32'h100);
        expect_write(32'h10, 3, val);
        expect_write(32'h14, 4, val + val);
        end_program();
        run_and_compare("memory");
        check_value(word_t'(u_mem.log_count), 32'd1, "store log length");
        check_value(u_mem.log_adr[0], 32'h100, "store address");
        check_value(u_mem.log_dat[0], val, "store data");
        check_value(word_t'(u_mem.log_sel[0]), 32'h0000000f, "store byte select");
    endtask

    task automatic test_branches();
        begin_program();
        emit(enc_i(op_addiu, 0, 1, 7));
        emit(enc_i(op_addiu, 0, 2, 7));
        emit(enc_i(op_beq, 1, 2, 3));           // taken to 0x18
        emit(enc_i(op_addiu, 0, 3, 1));         // delay slot
        emit(enc_i(op_addiu, 0, 4, 2));         // skipped
        emit(enc_i(op_addiu, 0, 4, 3));         // skipped
        emit(enc_i(op_bne, 1, 2, 4));           // not taken
        emit(enc_i(op_addiu, 0, 5, 4));         // delay slot
        emit(enc_i(op_addiu, 0, 6, 5));
        emit(enc_j(32'h34));
        emit(enc_i(op_addiu, 0, 7, 6));         // delay slot
        emit(enc_i(op_addiu, 0, 8, 9));         // skipped bne target
        emit(enc_i(op_addiu, 0, 8, 10));        // skipped
        emit(enc_r(fn_addu, 9, 3, 5, 0));
        expect_write(32'h00, 1, 32'd7);
        expect_write(32'h04, 2, 32'd7);
        expect_write(32'h0c, 3, 32'd1);
        expect_write(32'h1c, 5, 32'd4);
        expect_write(32'h20, 6, 32'd5);
        expect_write(32'h28, 7, 32'd6);
        expect_write(32'h34, 9, 32'd1 + 32'd4);
        end_program();
        run_and_compare("branches");
    endtask

    task automatic test_reg_zero();
        begin_program();
        emit(enc_i(op_addiu, 0, 0, 16'h0055));
        emit(enc_r(fn_addu, 1, 0, 0, 0));
        emit(enc_i(op_addiu, 1, 2, 3));
        expect_write(32'h00, 0, 32'h55);        // traced but never stored
        expect_write(32'h04, 1, 32'd0);
        expect_write(32'h08, 2, 32'd3);
        end_program();
        run_and_compare("register zero");
    endtask

    initial begin
        resetn     = 1'b0;
        rand_delay = 1'b0;
        test_reset();
        test_arith(1'b0);
        test_memory();
        test_branches();
        test_reg_zero();
        test_arith(1'b1);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: tb_memory.sv
// --------------------
// wishbone classic memory model for the testbench
// 0 to 3 wait cycles per transfer and a log of every store
// --------------------
`timescale 1ns/100ps

module tb_memory
    import wb_pkg::*;
#(
    parameter int unsigned seed = 32'h0
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    random_delay,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    logic [31:0] mem [512];         // 2 KiB word array
    logic [31:0] log_adr [16];      // store log in bus order
    logic [31:0] log_dat [16];
    logic [3:0]  log_sel [16];
    int          log_count;
    int          wait_cnt;
    int          delay;

    // address dependent pattern to make stray reads stand out
    task automatic fill();
        logic [31:0] adr;
        int          i;
        for (i = 0; i < 512; i++) begin
            adr    = i * 4;
            mem[i] = {~adr[15:0], adr[15:0]};
        end
        log_count = 0;
    endtask

    task automatic write_word(logic [31:0] adr, logic [31:0] data);
        mem[adr[10:2]] = data;
    endtask

    // --------------------
    // slave side on the falling edge
    // --------------------
    initial begin
        void'($urandom(seed));      // ack delays draw from this process
        bus_rsp   = '0;
        wait_cnt  = 0;
        delay     = 0;
        log_count = 0;
        forever begin
            @(negedge clk);
            if (!resetn) begin
                bus_rsp.ack <= 1'b0;
                wait_cnt    <= 0;
                delay       <= 0;
            end else if (bus_rsp.ack) begin
                bus_rsp.ack <= 1'b0;    // one ack per transfer
                wait_cnt    <= 0;
                delay       <= random_delay ? int'($urandom % 4) : 0;
            end else if (bus_req.cyc && bus_req.stb) begin
                if (wait_cnt < delay) begin
                    wait_cnt <= wait_cnt + 1;
                end else begin
                    bus_rsp.ack <= 1'b1;
                    if (bus_req.we) begin
                        mem[bus_req.adr[10:2]] <= bus_req.dat_w;
                        if (log_count < 16) begin
                            log_adr[log_count] <= bus_req.adr;
                            log_dat[log_count] <= bus_req.dat_w;
                            log_sel[log_count] <= bus_req.sel;
                        end
                        log_count <= log_count + 1;
                    end else begin
                        bus_rsp.dat_r <= mem[bus_req.adr[10:2]];
                    end
                end
            end
        end
    end

endmodule

// File: cpu_top.sv
// --------------------
// pipelined mips subset core with one shared wishbone port
// retire reports each register write for tracing
// --------------------
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
    import wb_pkg::*;
#(
    parameter word_t reset_vector = 32'hbfc00000
) (
    input  logic    clk,
    input  logic    resetn,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp,
    output retire_t retire
);

    wb_req_t fetch_req;
    wb_rsp_t fetch_rsp;
    wb_req_t data_req;
    wb_rsp_t data_rsp;
    logic    step;
    logic    stall_fetch;
    logic    redirect;
    logic    mem_busy;
    word_t   redirect_pc;
    if_id_t  if_id;
    id_ex_t  id_ex;
    fwd_t    ex_fwd;
    fwd_t    mem_fwd;

    fetch_unit #(
        .reset_vector (reset_vector)
    ) u_fetch (
        .clk         (clk),
        .resetn      (resetn),
        .stall_fetch (stall_fetch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_busy    (mem_busy),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .step        (step),
        .if_id       (if_id)
    );

    decode_unit u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .step        (step),
        .if_id       (if_id),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb          (retire),      // write-back port doubles as trace
        .stall_fetch (stall_fetch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .id_ex       (id_ex)
    );

    execute_unit u_execute (
        .clk      (clk),
        .resetn   (resetn),
        .step     (step),
        .id_ex    (id_ex),
        .data_req (data_req),
        .data_rsp (data_rsp),
        .mem_busy (mem_busy),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb       (retire)
    );

    bus_arbiter u_arbiter (
        .clk       (clk),
        .resetn    (resetn),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

endmodule

// File: bus_arbiter.sv
// --------------------
// grants the shared wishbone port to fetch or data
// data wins when both ask, a started transfer keeps the bus until ack
// --------------------
`timescale 1ns/100ps

module bus_arbiter
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  wb_req_t fetch_req,
    input  wb_req_t data_req,
    output wb_rsp_t fetch_rsp,
    output wb_rsp_t data_rsp,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    typedef enum logic [1:0] {idle, fetch_owner, data_owner} arb_state_t;

    arb_state_t state;
    logic       grant_fetch;
    logic       grant_data;

    always_comb begin
        grant_fetch = 1'b0;
        grant_data  = 1'b0;
        case (state)
            fetch_owner: grant_fetch = 1'b1;
            data_owner:  grant_data  = 1'b1;
            default: begin
                grant_data  = data_req.cyc;
                grant_fetch = fetch_req.cyc && !data_req.cyc;
            end
        endcase
    end

    always_comb begin
        if (grant_data)
            bus_req = data_req;
        else if (grant_fetch)
            bus_req = fetch_req;
        else
            bus_req = '0;
    end

    // ack only to the owner, read data shared
    assign fetch_rsp = '{ack: bus_rsp.ack && grant_fetch, dat_r: bus_rsp.dat_r};
    assign data_rsp  = '{ack: bus_rsp.ack && grant_data, dat_r: bus_rsp.dat_r};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else if (bus_rsp.ack) begin
            state <= idle;
        end else if (grant_data) begin
            state <= data_owner;
        end else if (grant_fetch) begin
            state <= fetch_owner;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        bus_req.stb && !bus_rsp.ack |=> $stable({grant_data, grant_fetch}));

endmodule

// File: execute_unit.sv
// --------------------
// alu, memory-stage data bus master and write-back register
// offers execute and memory results back to decode for forwarding
// --------------------
`timescale 1ns/100ps

module execute_unit
    import cpu_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    step,
    input  id_ex_t  id_ex,
    output wb_req_t data_req,
    input  wb_rsp_t data_rsp,
    output logic    mem_busy,
    output fwd_t    ex_fwd,
    output fwd_t    mem_fwd,
    output retire_t wb
);

    word_t   alu_result;
    ex_mem_t ex_mem;
    logic    mem_done;      // transfer of the memory-stage instruction is over

    always_comb begin
        case (id_ex.op)
            alu_add: alu_result = id_ex.a + id_ex.b;
            alu_sub: alu_result = id_ex.a - id_ex.b;
            alu_and: alu_result = id_ex.a & id_ex.b;
            alu_or:  alu_result = id_ex.a | id_ex.b;
            alu_xor: alu_result = id_ex.a ^ id_ex.b;
            alu_slt: alu_result = {31'b0, $signed(id_ex.a) < $signed(id_ex.b)};
            alu_sll: alu_result = id_ex.b << id_ex.a[4:0];
            alu_lui: alu_result = {id_ex.b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    assign ex_fwd = '{dst: id_ex.dst, value: alu_result, write: id_ex.write,
                      load: id_ex.load};

    // --------------------
    // memory stage
    // --------------------
    assign mem_busy = (ex_mem.load || ex_mem.store) && !mem_done;

    assign data_req = '{cyc: mem_busy, stb: mem_busy, we: ex_mem.store, sel: 4'hf,
                        adr: ex_mem.result, dat_w: ex_mem.store_data};

    assign mem_fwd.dst   = ex_mem.dst;
    assign mem_fwd.value = (ex_mem.load && data_rsp.ack) ? data_rsp.dat_r : ex_mem.result;
    assign mem_fwd.write = ex_mem.write;
    assign mem_fwd.load  = ex_mem.load;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_mem.load  <= 1'b0;
            ex_mem.store <= 1'b0;
            ex_mem.write <= 1'b0;
            mem_done     <= 1'b0;
        end else if (step) begin
            ex_mem   <= '{result: alu_result, store_data: id_ex.store_data,
                          dst: id_ex.dst, load: id_ex.load, store: id_ex.store,
                          write: id_ex.write, pc: id_ex.pc};
            mem_done <= 1'b0;
        end else if (data_rsp.ack) begin
            mem_done <= 1'b1;
            if (ex_mem.load) begin
                ex_mem.result <= data_rsp.dat_r;    // address no longer needed
            end
        end
    end

    // write-back, one cycle pulse per retired write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= step && ex_mem.write;
        end
        if (step) begin
            wb.pc   <= ex_mem.pc;
            wb.rd   <= ex_mem.dst;
            wb.data <= ex_mem.result;
        end
    end

    // the pipeline only steps once the data transfer has been acknowledged
    assert property (@(posedge clk) disable iff (!resetn)
        $fell(mem_busy) |-> $past(data_rsp.ack));

endmodule

// File: decode_unit.sv
// --------------------
// register file, instruction decode, operand forwarding
// load-use interlock and branch resolution with one delay slot
// --------------------
`timescale 1ns/100ps

module decode_unit
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    step,
    input  if_id_t  if_id,
    input  fwd_t    ex_fwd,
    input  fwd_t    mem_fwd,
    input  retire_t wb,
    output logic    stall_fetch,
    output logic    redirect,
    output word_t   redirect_pc,
    output id_ex_t  id_ex
);

    word_t     regs [32];
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm_sext;
    word_t     imm_zext;
    word_t     pc_plus4;
    logic      uses_rs;
    logic      uses_rt;
    logic      take;
    id_ex_t    dec;

    // newest value wins from execute to memory to write-back to the array
    function automatic word_t read_operand(reg_addr_t r, word_t rf_val, fwd_t ex,
                                           fwd_t mem, retire_t w);
        if (r == '0)
            return '0;
        if (ex.write && ex.dst == r)
            return ex.value;
        if (mem.write && mem.dst == r)
            return mem.value;
        if (w.valid && w.rd == r)
            return w.data;
        return rf_val;
    endfunction

    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign imm_sext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
    assign imm_zext = {16'h0000, if_id.instr[15:0]};
    assign pc_plus4 = if_id.pc + 32'd4;
    assign rs_val   = read_operand(rs, regs[rs], ex_fwd, mem_fwd, wb);
    assign rt_val   = read_operand(rt, regs[rt], ex_fwd, mem_fwd, wb);

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // --------------------
    // decode
    // --------------------
    always_comb begin
        dec            = '0;
        dec.op         = alu_add;
        dec.a          = rs_val;
        dec.b          = imm_sext;
        dec.store_data = rt_val;
        dec.dst        = rt;
        dec.pc         = if_id.pc;
        uses_rs        = 1'b1;
        uses_rt        = 1'b0;
        take           = 1'b0;
        redirect_pc    = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (opcode_t'(if_id.instr[31:26]))
            op_special: begin
                dec.b     = rt_val;
                dec.dst   = if_id.instr[15:11];
                dec.write = 1'b1;
                uses_rt   = 1'b1;
                case (funct_t'(if_id.instr[5:0]))
                    fn_addu: dec.op = alu_add;
                    fn_subu: dec.op = alu_sub;
                    fn_and:  dec.op = alu_and;
                    fn_or:   dec.op = alu_or;
                    fn_xor:  dec.op = alu_xor;
                    fn_slt:  dec.op = alu_slt;
                    fn_sll: begin
                        dec.op  = alu_sll;
                        dec.a   = word_t'(if_id.instr[10:6]);  // shamt
                        uses_rs = 1'b0;
                    end
                    default: dec.write = 1'b0;
                endcase
            end
            op_addiu: dec.write = 1'b1;
            op_andi, op_ori: begin
                dec.op    = if_id.instr[26] ? alu_or : alu_and;
                dec.b     = imm_zext;
                dec.write = 1'b1;
            end
            op_lui: begin
                dec.op    = alu_lui;
                dec.write = 1'b1;
                uses_rs   = 1'b0;
            end
            op_lw: begin
                dec.load  = 1'b1;
                dec.write = 1'b1;
            end
            op_sw: begin
                dec.store = 1'b1;
                uses_rt   = 1'b1;
            end
            op_beq, op_bne: begin
                uses_rt = 1'b1;
                take    = (rs_val == rt_val) ^ if_id.instr[26];  // bne inverts
            end
            op_j: begin
                uses_rs     = 1'b0;
                take        = 1'b1;
                redirect_pc = {pc_plus4[31:28], if_id.instr[25:0], 2'b00};
            end
            default: ;
        endcase

        // load result not ready before the memory stage
        stall_fetch = ex_fwd.load && ex_fwd.write && ex_fwd.dst != '0 &&
                      ((uses_rs && ex_fwd.dst == rs) || (uses_rt && ex_fwd.dst == rt));
        redirect    = take && !stall_fetch;
        if (stall_fetch) begin
            dec.load  = 1'b0;
            dec.store = 1'b0;
            dec.write = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_ex.load  <= 1'b0;
            id_ex.store <= 1'b0;
            id_ex.write <= 1'b0;
        end else if (step) begin
            id_ex <= dec;               // bubble when stalled
        end
    end

    // the load-use bubble releases the interlock after one step
    assert property (@(posedge clk) disable iff (!resetn)
        step && stall_fetch |=> !stall_fetch);

endmodule

// File: fetch_unit.sv
// --------------------
// program counter and instruction bus master
// one read per instruction and the pipeline step
// --------------------
`timescale 1ns/100ps

module fetch_unit
    import cpu_pkg::*;
    import wb_pkg::*;
#(
    parameter word_t reset_vector = 32'hbfc00000
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    stall_fetch,
    input  logic    redirect,
    input  word_t   redirect_pc,
    input  logic    mem_busy,
    output wb_req_t fetch_req,
    input  wb_rsp_t fetch_rsp,
    output logic    step,
    output if_id_t  if_id
);

    word_t pc;                  // address of the instruction held or in flight
    word_t instr_q;
    word_t target_q;            // branch target, used after the delay slot
    logic  fetching;
    logic  have_instr;
    logic  redirect_pending;
    word_t next_pc;

    assign step    = have_instr && !mem_busy;
    assign next_pc = redirect_pending ? target_q : pc + 32'd4;
    assign if_id   = '{instr: instr_q, pc: pc};

    assign fetch_req = '{cyc: fetching, stb: fetching, we: 1'b0, sel: 4'hf,
                         adr: pc, dat_w: '0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc               <= reset_vector;
            fetching         <= 1'b0;
            have_instr       <= 1'b0;
            redirect_pending <= 1'b0;
        end else if (fetch_rsp.ack) begin
            fetching   <= 1'b0;
            have_instr <= 1'b1;
        end else if (step && !stall_fetch) begin
            pc               <= next_pc;
            fetching         <= 1'b1;   // next read goes out in the following cycle
            have_instr       <= 1'b0;
            redirect_pending <= redirect;
        end else if (!have_instr) begin
            fetching <= 1'b1;           // first read after reset
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_rsp.ack) begin
            instr_q <= fetch_rsp.dat_r;
        end
        if (step && redirect) begin
            target_q <= redirect_pc;
        end
    end

    // targets from decode and the reset vector keep reads word aligned
    assert property (@(posedge clk) disable iff (!resetn)
        fetch_req.stb |-> fetch_req.adr[1:0] == 2'b00);

    // a read stays on the bus with the same address until its ack
    assert property (@(posedge clk) disable iff (!resetn)
        fetch_req.stb && !fetch_rsp.ack |=> fetch_req.stb && $stable(fetch_req.adr));

endmodule

// File: wb_pkg.sv
// --------------------
// wishbone classic request and response bundles
// shared by both bus masters, the arbiter and the external port
// --------------------
package wb_pkg;

    // master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

// File: cpu_pkg.sv
// --------------------
// instruction encodings and pipeline register types of the processor
// imported by every pipeline stage and by the top level
// --------------------
package cpu_pkg;

    typedef logic [31:0] word_t;      // data word or byte address
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function codes of op_special, bits 5:0
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_lui
    } alu_op_t;

    // --------------------
    // pipeline registers
    // --------------------
    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        alu_op_t   op;
        word_t     a;
        word_t     b;
        word_t     store_data;
        reg_addr_t dst;
        logic      load;
        logic      store;
        logic      write;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        word_t     result;      // alu result, load/store address, then load data
        word_t     store_data;
        reg_addr_t dst;
        logic      load;
        logic      store;
        logic      write;
        word_t     pc;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t dst;
        word_t     value;
        logic      write;
        logic      load;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage
